// File: common/panel_pkg.sv
package panel_pkg;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_RESERVED   = 2'd2,
        PRIV_MACHINE    = 2'd3
    } priv_e;

    typedef struct packed {
        logic        init_start;  // image load begins
        logic        init_done;
        logic        data_we;
        logic        busy;
        priv_e       priv;
        logic [31:0] pc;
        logic [31:0] ir;
        logic [31:0] odata;       // program output word
    } core_status_t;

    typedef struct packed {
        logic halt;
        logic finish;
    } core_event_t;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic centre;
    } buttons_t;

    typedef struct packed {
        logic       kbd_we;
        logic [7:0] kbd_data;
        logic       mouse_we;
        logic [7:0] mouse_data;
    } ps2_event_t;

    typedef struct packed {
        logic [7:0] sg;  // cathodes, active low
        logic [7:0] an;  // anodes, active low
    } seg_drive_t;

    typedef struct packed {
        logic b;
        logic g;
        logic r;
    } rgb_t;

    typedef struct packed {
        logic init_done;
        logic data_we;
        logic busy;
        logic stopped;
    } status_led_t;

    // bit 7 is the decimal point, bits 6:0 are segments a to g
    typedef logic [7:0] glyph_t;

    localparam int          SCAN_DIV       = 16000;  // cycles per digit
    localparam int          SCAN_CNT_BITS  = $clog2(SCAN_DIV);
    localparam int          LOAD_STEP_BITS = 16;
    localparam logic [31:0] RUN_TIMEOUT    = 32'h0200_0000;
    localparam int          BLINK_BITS     = 4;
    localparam int          PWM_BITS       = 12;
    localparam int          BREATH_STEP_B  = 2;
    localparam int          BREATH_STEP_G  = 3;
    localparam int          BREATH_STEP_R  = 5;
    localparam int          BREATH_INIT_G  = 64;
    localparam int          BREATH_INIT_R  = 512;

    localparam glyph_t GLYPH_BLANK = 8'b0000_0000;
    localparam glyph_t GLYPH_DP    = 8'b1000_0000;
    localparam glyph_t GLYPH_CAP_A = 8'b0111_0111;
    localparam glyph_t GLYPH_R     = 8'b0000_0101;
    localparam glyph_t GLYPH_C     = 8'b0000_1101;
    localparam glyph_t GLYPH_H     = 8'b0001_0111;
    localparam glyph_t GLYPH_P     = 8'b0110_0111;
    localparam glyph_t GLYPH_O     = 8'b0001_1101;
    localparam glyph_t GLYPH_L     = 8'b0000_1110;
    localparam glyph_t GLYPH_A     = 8'b0111_1101;
    localparam glyph_t GLYPH_D     = 8'b0011_1101;
    localparam glyph_t GLYPH_I     = 8'b0001_0000;
    localparam glyph_t GLYPH_N     = 8'b0001_0101;
    localparam glyph_t GLYPH_G     = 8'b1111_1011;  // tail lit on the dp

    localparam glyph_t HEX_FONT [0:15] = '{
        8'b0111_1110, 8'b0011_0000, 8'b0110_1101, 8'b0111_1001,
        8'b0011_0011, 8'b0101_1011, 8'b0101_1111, 8'b0111_0000,
        8'b0111_1111, 8'b0111_1011, 8'b0111_0111, 8'b0001_1111,
        8'b0100_1110, 8'b0011_1101, 8'b0100_1111, 8'b0100_0111
    };

    // index is the digit number, leftmost digit first
    localparam glyph_t IDLE_BANNER [7:0] = '{
        GLYPH_CAP_A, GLYPH_R, GLYPH_C, GLYPH_H,
        GLYPH_P, GLYPH_R, GLYPH_O, GLYPH_C
    };

    localparam glyph_t LOAD_BANNER [0:15] = '{
        GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK,
        GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK, GLYPH_L,
        GLYPH_O, GLYPH_A, GLYPH_D, GLYPH_I,
        GLYPH_N, GLYPH_G, GLYPH_DP, GLYPH_DP
    };

endpackage

// File: source/run_monitor.sv
`timescale 1ns/10ps

module run_monitor import panel_pkg::*; (
    input  logic         CORE_CLK,
    input  logic         CORE_RST_X,
    input  core_status_t status,
    input  core_event_t  events,
    input  buttons_t     buttons,
    output logic         stopped,
    output logic         load_active,
    output logic [3:0]   load_step
);

    logic                      stop_req;
    logic [LOAD_STEP_BITS-1:0] step_cnt;  // cycles within one banner step

    // any one source ends the run
    assign stop_req = buttons.centre
                    | events.halt
                    | events.finish
                    | (status.odata > RUN_TIMEOUT);

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            stopped <= 1'b0;
        end else if (stop_req) begin
            stopped <= 1'b1;  // sticky until reset
        end
    end

    // load window from init_start to init_done
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            load_active <= 1'b0;
        end else if (!load_active && status.init_start && !status.init_done) begin
            load_active <= 1'b1;
        end else if (status.init_done) begin
            load_active <= 1'b0;
        end
    end

    // counter holds its value outside the window
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            step_cnt  <= '0;
            load_step <= '0;
        end else if (load_active) begin
            step_cnt <= step_cnt + 1'b1;
            if (&step_cnt) begin
                load_step <= load_step + 1'b1;  // advance on wrap
            end
        end
    end

    stop_is_sticky: assert property (
        @(posedge CORE_CLK) disable iff (!CORE_RST_X)
        stopped |=> stopped
    );

endmodule

// File: source/display_source.sv
`timescale 1ns/10ps

module display_source import panel_pkg::*; (
    input  logic         CORE_CLK,
    input  logic         CORE_RST_X,
    input  ps2_event_t   ps2,
    input  buttons_t     buttons,
    input  core_status_t status,
    output logic [31:0]  value
);

    // mouse pair in the upper half, keyboard pair in the lower half
    logic [31:0] history;
    logic        blank_sel;

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            history <= '0;
        end else begin
            if (ps2.kbd_we) begin
                history[15:0] <= {history[7:0], ps2.kbd_data};  // previous key moves up
            end
            if (ps2.mouse_we) begin
                history[31:16] <= {history[23:16], ps2.mouse_data};
            end
        end
    end

    assign blank_sel = buttons.up | buttons.down | buttons.centre;

    // button priority follows the board labels
    always_ff @(posedge CORE_CLK) begin
        if (blank_sel) begin
            value <= '0;
        end else if (buttons.left) begin
            value <= status.pc;
        end else if (buttons.right) begin
            value <= status.ir;
        end else begin
            value <= history;
        end
    end

endmodule

// File: seven_seg/seg_scan.sv
`timescale 1ns/10ps

module seg_scan import panel_pkg::*; (
    input  logic        CORE_CLK,
    input  logic        CORE_RST_X,
    input  logic [31:0] value,
    input  logic        init_done,
    input  logic        load_active,
    input  logic [3:0]  load_step,
    output seg_drive_t  seg
);

    typedef enum logic [1:0] {
        MODE_HEX,
        MODE_IDLE,
        MODE_LOAD
    } scan_mode_e;

    logic [SCAN_CNT_BITS-1:0] scan_cnt;
    logic                     scan_step;   // digit advance strobe
    logic [7:0]               next_an;
    logic [2:0]               next_digit;
    logic [3:0]               nibble;
    logic [3:0]               load_index;
    scan_mode_e               mode;
    glyph_t                   glyph;

    // position of the single low anode bit
    function automatic logic [2:0] low_digit(input logic [7:0] an);
        logic [2:0] idx;
        idx = 3'd0;
        for (int i = 0; i < 8; i++) begin
            if (!an[i]) begin
                idx = 3'(i);
            end
        end
        return idx;
    endfunction

    assign scan_step = (scan_cnt == SCAN_CNT_BITS'(SCAN_DIV - 1));

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            scan_cnt <= '0;
        end else if (scan_step) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // first step lights digit 0, then the low bit rotates upward
    assign next_an = (&seg.an) ? 8'b1111_1110 : {seg.an[6:0], seg.an[7]};

    assign next_digit = low_digit(next_an);

    assign nibble = value[{next_digit, 2'b00} +: 4];

    // banner window slides one entry per load step
    assign load_index = load_step + 4'd7 - {1'b0, next_digit};

    always_comb begin
        if (load_active) begin
            mode = MODE_LOAD;
        end else if (!init_done) begin
            mode = MODE_IDLE;
        end else begin
            mode = MODE_HEX;
        end
    end

    always_comb begin
        case (mode)
            MODE_LOAD: begin
                glyph = LOAD_BANNER[load_index];
            end
            MODE_IDLE: begin
                glyph = IDLE_BANNER[next_digit];
            end
            default: begin
                glyph = HEX_FONT[nibble];
            end
        endcase
    end

    // anode and cathodes move together so the glyph matches its digit
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            seg.sg <= '1;   // all segments dark
            seg.an <= '1;   // no digit selected yet
        end else if (scan_step) begin
            seg.sg <= ~glyph;
            seg.an <= next_an;
        end
    end

    // never two digits driven at once
    an_one_cold: assert property (
        @(posedge CORE_CLK) disable iff (!CORE_RST_X)
        $countones(~seg.an) <= 1
    );

endmodule

// File: source/rgb_status.sv
`timescale 1ns/10ps

module rgb_status import panel_pkg::*; (
    input  logic  CORE_CLK,
    input  logic  CORE_RST_X,
    input  priv_e priv,
    input  logic  init_done,
    input  logic  load_active,
    output rgb_t  rgb
);

    // top bit flips the duty direction, so each colour ramps up and down
    typedef logic [PWM_BITS:0] phase_t;

    logic [PWM_BITS-1:0]   pwm_cnt;
    logic [BLINK_BITS-1:0] blink_cnt;
    phase_t                phase_b;
    phase_t                phase_g;
    phase_t                phase_r;
    rgb_t                  breath;

    function automatic logic breath_bit(input phase_t phase,
                                        input logic [PWM_BITS-1:0] pwm);
        logic rising;
        rising = phase[PWM_BITS];
        return rising ? (phase[PWM_BITS-1:0] < pwm) : (phase[PWM_BITS-1:0] >= pwm);
    endfunction

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            pwm_cnt   <= '0;
            blink_cnt <= '0;
        end else begin
            pwm_cnt   <= pwm_cnt + 1'b1;
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    // colours start out of phase and drift at different rates
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            phase_b <= '0;
            phase_g <= phase_t'(BREATH_INIT_G);
            phase_r <= phase_t'(BREATH_INIT_R);
        end else if (pwm_cnt == '0) begin
            phase_b <= phase_b + phase_t'(BREATH_STEP_B);
            phase_g <= phase_g + phase_t'(BREATH_STEP_G);
            phase_r <= phase_r + phase_t'(BREATH_STEP_R);
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            breath <= '0;
        end else begin
            breath.b <= breath_bit(phase_b, pwm_cnt);
            breath.g <= breath_bit(phase_g, pwm_cnt);
            breath.r <= breath_bit(phase_r, pwm_cnt);
        end
    end

    // short flash once per blink period after init
    always_comb begin
        rgb = '0;
        if (load_active) begin
            rgb = breath;
        end else if (init_done && blink_cnt == '0) begin
            case (priv)
                PRIV_USER:       rgb.b = 1'b1;
                PRIV_SUPERVISOR: rgb.g = 1'b1;
                PRIV_MACHINE:    rgb.r = 1'b1;
                default:         rgb   = '0;  // reserved level stays dark
            endcase
        end
    end

endmodule

// File: source/status_panel.sv
`timescale 1ns/10ps

module status_panel import panel_pkg::*; (
    input  logic         CORE_CLK,
    input  logic         CORE_RST_X,
    input  core_status_t status,
    input  core_event_t  events,
    input  buttons_t     buttons,
    input  ps2_event_t   ps2,
    output seg_drive_t   seg,
    output rgb_t         rgb,
    output status_led_t  leds
);

    logic        stopped;
    logic        load_active;
    logic [3:0]  load_step;    // banner scroll position
    logic [31:0] disp_value;

    run_monitor u_run_monitor (
        .CORE_CLK    (CORE_CLK),
        .CORE_RST_X  (CORE_RST_X),
        .status      (status),
        .events      (events),
        .buttons     (buttons),
        .stopped     (stopped),
        .load_active (load_active),
        .load_step   (load_step)
    );

    display_source u_display_source (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .ps2        (ps2),
        .buttons    (buttons),
        .status     (status),
        .value      (disp_value)
    );

    seg_scan u_seg_scan (
        .CORE_CLK    (CORE_CLK),
        .CORE_RST_X  (CORE_RST_X),
        .value       (disp_value),
        .init_done   (status.init_done),
        .load_active (load_active),
        .load_step   (load_step),
        .seg         (seg)
    );

    rgb_status u_rgb_status (
        .CORE_CLK    (CORE_CLK),
        .CORE_RST_X  (CORE_RST_X),
        .priv        (status.priv),
        .init_done   (status.init_done),
        .load_active (load_active),
        .rgb         (rgb)
    );

    // plain lamps straight from the core levels
    assign leds.init_done = status.init_done;
    assign leds.data_we   = status.data_we;
    assign leds.busy      = status.busy;
    assign leds.stopped   = stopped;

endmodule

// File: bench/tb_status_panel.sv
`timescale 1ns/10ps

module tb_status_panel import panel_pkg::*; ();

    typedef logic [PWM_BITS:0] phase_t;

    localparam logic [31:0] SEED        = 32'h4016d23b;
    localparam int          CLK_HALF    = 10;
    localparam int          IDLE_CYCLES = 9 * SCAN_DIV;
    localparam int          LOAD_CYCLES = 4 << LOAD_STEP_BITS;  // four banner steps
    localparam int          HEX_ROUNDS  = 8;
    localparam int          HEX_HOLD    = 9 * SCAN_DIV;
    localparam int          PRIV_ROUNDS = 32;
    localparam int          LAMP_CYCLES = 256;
    localparam longint      RUN_CYCLES  = IDLE_CYCLES + LOAD_CYCLES + 256
                                        + HEX_ROUNDS * (HEX_HOLD + 64)
                                        + PRIV_ROUNDS * 64 + LAMP_CYCLES + 5 * 16;
    localparam longint      WATCHDOG_NS = RUN_CYCLES * 2 * CLK_HALF * 3 / 2;
    localparam int          BREATH_STEP [3] = '{BREATH_STEP_B, BREATH_STEP_G, BREATH_STEP_R};

    logic         CORE_CLK = 1'b0;
    logic         CORE_RST_X;
    core_status_t status;
    core_event_t  events;
    buttons_t     buttons;
    ps2_event_t   ps2;
    seg_drive_t   seg;
    rgb_t         rgb;
    status_led_t  leds;

    // reference model
    logic [31:0]               m_history;
    logic [31:0]               m_value;
    logic                      m_stopped;
    logic                      m_load;
    logic [LOAD_STEP_BITS-1:0] m_step_cnt;
    logic [3:0]                m_step;
    int                        m_scan_cnt;
    logic                      m_scanning;  // first digit step done
    logic [2:0]                m_digit;
    logic [2:0]                next_digit;
    logic [7:0]                m_sg;
    logic [7:0]                m_an;
    logic [PWM_BITS-1:0]       m_pwm;
    logic [BLINK_BITS-1:0]     m_blink;
    phase_t                    m_phase [3];  // blue, green, red
    logic [2:0]                m_breath;     // b, g, r
    int                        errors = 0;
    bit                        checking = 1'b0;

    status_panel u_dut (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .status     (status),
        .events     (events),
        .buttons    (buttons),
        .ps2        (ps2),
        .seg        (seg),
        .rgb        (rgb),
        .leds       (leds)
    );

    always #(CLK_HALF) CORE_CLK = ~CORE_CLK;

    function automatic logic [31:0] select_word(input logic [31:0] hist);
        if (buttons.up || buttons.down || buttons.centre) begin
            return 32'd0;
        end else if (buttons.left) begin
            return status.pc;
        end else if (buttons.right) begin
            return status.ir;
        end
        return hist;
    endfunction

    function automatic glyph_t expected_glyph(input logic [2:0] k);
        logic [3:0] idx;
        idx = m_step + 4'd7 - {1'b0, k};  // banner window for this digit
        if (m_load) begin
            return LOAD_BANNER[idx];
        end else if (!status.init_done) begin
            return IDLE_BANNER[k];
        end
        return HEX_FONT[m_value[4 * k +: 4]];
    endfunction

    function automatic logic breath_on(input phase_t phase, input logic [PWM_BITS-1:0] pwm);
        if (phase[PWM_BITS]) begin
            return phase[PWM_BITS-1:0] < pwm;
        end
        return phase[PWM_BITS-1:0] >= pwm;
    endfunction

    function automatic logic [2:0] expected_rgb();
        if (m_load) begin
            return m_breath;
        end else if (!status.init_done || m_blink != '0) begin
            return 3'b000;
        end
        case (status.priv)
            PRIV_USER:       return 3'b100;
            PRIV_SUPERVISOR: return 3'b010;
            PRIV_MACHINE:    return 3'b001;
            default:         return 3'b000;
        endcase
    endfunction

    always @(posedge CORE_CLK) begin
        m_value <= select_word(m_history);  // display word has no reset
        if (!CORE_RST_X) begin
            m_history  <= '0;
            m_stopped  <= 1'b0;
            m_load     <= 1'b0;
            m_step_cnt <= '0;
            m_step     <= '0;
            m_scan_cnt <= 0;
            m_scanning <= 1'b0;
            m_digit    <= '0;
            m_sg       <= '1;
            m_an       <= '1;
            m_pwm      <= '0;
            m_blink    <= '0;
            m_phase[0] <= '0;
            m_phase[1] <= phase_t'(BREATH_INIT_G);
            m_phase[2] <= phase_t'(BREATH_INIT_R);
            m_breath   <= '0;
        end else begin
            if (ps2.kbd_we) begin
                m_history[15:0] <= {m_history[7:0], ps2.kbd_data};
            end
            if (ps2.mouse_we) begin
                m_history[31:16] <= {m_history[23:16], ps2.mouse_data};
            end
            if (buttons.centre || events.halt || events.finish || status.odata > RUN_TIMEOUT) begin
                m_stopped <= 1'b1;
            end
            if (status.init_done) begin
                m_load <= 1'b0;
            end else if (status.init_start) begin
                m_load <= 1'b1;
            end
            if (m_load) begin
                m_step_cnt <= m_step_cnt + 1'b1;
                if (m_step_cnt == '1) begin
                    m_step <= m_step + 1'b1;
                end
            end
            if (m_scan_cnt == SCAN_DIV - 1) begin
                next_digit = m_scanning ? m_digit + 3'd1 : 3'd0;
                m_scan_cnt <= 0;
                m_scanning <= 1'b1;
                m_digit    <= next_digit;
                m_an       <= ~(8'b1 << next_digit);
                m_sg       <= ~expected_glyph(next_digit);
            end else begin
                m_scan_cnt <= m_scan_cnt + 1;
            end
            m_pwm   <= m_pwm + 1'b1;
            m_blink <= m_blink + 1'b1;
            for (int i = 0; i < 3; i++) begin
                if (m_pwm == '0) begin
                    m_phase[i] <= m_phase[i] + phase_t'(BREATH_STEP[i]);
                end
                m_breath[2 - i] <= breath_on(m_phase[i], m_pwm);
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    // outputs are settled half a cycle after the edge
    always @(negedge CORE_CLK) begin
        if (checking) begin
            check_value("seg", 32'(seg), {16'd0, m_sg, m_an});
            check_value("rgb", 32'(rgb), 32'(expected_rgb()));
            check_value("leds", 32'(leds),
                        {28'd0, status.init_done, status.data_we, status.busy, m_stopped});
        end
    end

    task automatic next_cycle();
        @(posedge CORE_CLK);
        #2;
    endtask

    task automatic apply_reset();
        CORE_RST_X = 1'b0;
        repeat (2) next_cycle();
        CORE_RST_X = 1'b1;
    endtask

    task automatic check_stop_source(input int src, input logic expect_stop);
        next_cycle();
        apply_reset();
        case (src)
            0:       buttons.centre = 1'b1;
            1:       events.halt = 1'b1;
            2:       events.finish = 1'b1;
            3:       status.odata = RUN_TIMEOUT + 32'd1;
            default: status.odata = RUN_TIMEOUT;  // at the limit, keeps running
        endcase
        @(negedge CORE_CLK);
        check_value("leds.stopped", 32'(leds.stopped), 32'd0);
        next_cycle();
        buttons = '0;
        events  = '0;
        status  = '0;
        @(negedge CORE_CLK);
        check_value("leds.stopped", 32'(leds.stopped), 32'(expect_stop));
        repeat (8) next_cycle();
        @(negedge CORE_CLK);
        check_value("leds.stopped", 32'(leds.stopped), 32'(expect_stop));
    endtask

    initial begin
        void'($urandom(SEED));
        status  = '0;
        events  = '0;
        buttons = '0;
        ps2     = '0;
        apply_reset();
        checking = 1'b1;
        repeat (IDLE_CYCLES) next_cycle();  // idle banner scan

        status.priv = priv_e'(2'($urandom_range(0, 3)));
        status.init_start = 1'b1;
        next_cycle();
        status.init_start = 1'b0;
        repeat (LOAD_CYCLES) next_cycle();
        status.init_done = 1'b1;
        repeat (256) next_cycle();

        repeat (HEX_ROUNDS) begin
            status.pc = $urandom;
            status.ir = $urandom;
            buttons   = '0;
            case ($urandom_range(0, 3))
                0:       buttons = '0;
                1:       buttons.left = 1'b1;
                2:       buttons.right = 1'b1;
                default: buttons = 5'($urandom) & 5'b11110;  // centre would stop the run
            endcase
            repeat (64) begin
                ps2.kbd_we     = ($urandom_range(0, 3) == 0);
                ps2.kbd_data   = 8'($urandom);
                ps2.mouse_we   = ($urandom_range(0, 3) == 0);
                ps2.mouse_data = 8'($urandom);
                next_cycle();
            end
            ps2 = '0;
            repeat (HEX_HOLD) next_cycle();
        end
        buttons = '0;

        repeat (PRIV_ROUNDS) begin
            status.priv = priv_e'(2'($urandom_range(0, 3)));
            repeat (64) next_cycle();
        end

        repeat (LAMP_CYCLES) begin
            status.init_done = 1'($urandom);
            status.data_we   = 1'($urandom);
            status.busy      = 1'($urandom);
            next_cycle();
        end

        status = '0;
        for (int src = 0; src < 4; src++) begin
            check_stop_source(src, 1'b1);
        end
        check_stop_source(4, 1'b0);

        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Some tests failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

// File: all.f
common/panel_pkg.sv
source/run_monitor.sv
source/display_source.sv
seven_seg/seg_scan.sv
source/rgb_status.sv
source/status_panel.sv
bench/tb_status_panel.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_status_panel -Mdir obj_dir -f all.f

./obj_dir/Vtb_status_panel > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
grep -q "All tests passed" sim.log
